//--- common/fetch_cfg.svh
`ifndef FETCH_CFG_SVH
`define FETCH_CFG_SVH

// boot address, inside kseg1
`define FETCH_RESET_PC 32'hBFC0_0000

// kseg0/kseg1 window, top three bits dropped for the physical address
`define FETCH_KSEG_LO 32'h8000_0000
`define FETCH_KSEG_HI 32'hBFFF_FFFF

// address error on load / instruction fetch
`define FETCH_EXC_ADEL 8'h04

`endif

//--- common/fetch_pkg.sv
`default_nettype none

package fetch_pkg;

    // ----------------------------------------------------------------------
    // branch condition codes handed back from decode
    // ----------------------------------------------------------------------
    typedef enum logic [2:0] {
        cond_none   = 3'd0,
        cond_eq     = 3'd1,
        cond_ne     = 3'd2,
        cond_gez    = 3'd3,
        cond_gtz    = 3'd4,
        cond_lez    = 3'd5,
        cond_ltz    = 3'd6,
        cond_always = 3'd7
    } branch_cond_e;

    // how the redirect target is built
    typedef enum logic [1:0] {
        tk_rel = 2'd0,
        tk_abs = 2'd1,
        tk_reg = 2'd2
    } target_kind_e;

    // ----------------------------------------------------------------------
    // branch / jump instruction word, two views of the same bits
    // ----------------------------------------------------------------------
    typedef struct packed {
        logic [5:0]  opcode;
        logic [4:0]  rs;
        logic [4:0]  rt;
        logic [15:0] imm;
    } i_form_t;

    typedef struct packed {
        logic [5:0]  opcode;
        logic [25:0] instr_index;
    } j_form_t;

    typedef union packed {
        i_form_t i_form;
        j_form_t j_form;
    } instr_word_u;

endpackage

`default_nettype wire

//--- rtl/branch/branch_cond.sv
`default_nettype none

module branch_cond
    import fetch_pkg::*;
(
    input  wire logic [31:0]  rs_r,
    input  wire branch_cond_e cond_r,
    input  wire logic [31:0]  rt_r,
    output logic              taken
);

    logic rs_neg;
    logic rs_zero;
    logic rs_eq_rt;

    // sign and zero flags, no subtractor needed
    assign rs_neg   = rs_r[31];
    assign rs_zero  = (rs_r == 32'd0);
    assign rs_eq_rt = (rs_r == rt_r);

    // ----------------------------------------------------------------------
    // condition decode
    // ----------------------------------------------------------------------
    always_comb begin
        case (cond_r)
            cond_none: begin
                taken = 1'b0;
            end
            cond_eq: begin
                taken = rs_eq_rt;
            end
            cond_ne: begin
                taken = !rs_eq_rt;
            end
            cond_gez: begin
                taken = !rs_neg;
            end
            cond_gtz: begin
                // positive and nonzero
                taken = !rs_neg && !rs_zero;
            end
            cond_lez: begin
                taken = rs_neg || rs_zero;
            end
            cond_ltz: begin
                taken = rs_neg;
            end
            cond_always: begin
                taken = 1'b1;
            end
            default: begin
                taken = 1'b0;
            end
        endcase
    end

endmodule

`default_nettype wire

//--- rtl/branch/target_calc.sv
`default_nettype none

module target_calc
    import fetch_pkg::*;
(
    input  wire logic [31:0]  base_pc_r,
    input  wire logic [31:0]  rs_r,
    input  wire instr_word_u  instr_r,
    input  wire target_kind_e kind_r,
    output logic [31:0]       target
);

    logic [31:0] offset_ext;
    logic [31:0] rel_target;
    logic [31:0] abs_target;

    // ----------------------------------------------------------------------
    // i-type view: 16-bit offset, word aligned, sign extended
    // ----------------------------------------------------------------------
    assign offset_ext = {{14{instr_r.i_form.imm[15]}}, instr_r.i_form.imm, 2'b00};
    assign rel_target = base_pc_r + offset_ext;

    // j-type view: region of the delay slot plus the 26-bit index
    assign abs_target = {base_pc_r[31:28], instr_r.j_form.instr_index, 2'b00};

    always_comb begin
        case (kind_r)
            tk_rel: begin
                target = rel_target;
            end
            tk_abs: begin
                target = abs_target;
            end
            tk_reg: begin
                target = rs_r;
            end
            default: begin
                // unused code, fall back to the delay slot
                target = base_pc_r;
            end
        endcase
    end

endmodule

`default_nettype wire

//--- rtl/redirect_latch.sv
`default_nettype none

`include "fetch_cfg.svh"

module redirect_latch
    import fetch_pkg::*;
(
    input  wire logic         clk,
    input  wire logic         rst_n,
    input  wire logic         id_allowin,
    input  wire logic [31:0]  seq_pc,
    input  wire logic [31:0]  rs_value,
    input  wire logic [31:0]  rt_value,
    input  wire instr_word_u  branch_instr,
    input  wire branch_cond_e cond,
    input  wire target_kind_e kind,
    input  wire logic [31:0]  fetch_pc,
    output logic              if_valid,
    output logic [31:0]       seq_pc_r,
    output logic [31:0]       base_pc_r,
    output logic [31:0]       rs_r,
    output logic [31:0]       rt_r,
    output instr_word_u       instr_r,
    output branch_cond_e      cond_r,
    output target_kind_e      kind_r
);

    logic transfer;

    // stage handshake, fetch is always ready once out of reset
    assign transfer = if_valid && id_allowin;

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            if_valid <= 1'b0;
        end else begin
            if_valid <= 1'b1;
        end
    end

    // ----------------------------------------------------------------------
    // redirect control, reset to boot address with no branch pending
    // ----------------------------------------------------------------------
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            seq_pc_r  <= `FETCH_RESET_PC;
            base_pc_r <= `FETCH_RESET_PC;
            cond_r    <= cond_none;
            kind_r    <= tk_rel;
        end else if (transfer) begin
            seq_pc_r  <= seq_pc;
            // current fetch pc is the delay slot of the branch in decode
            base_pc_r <= fetch_pc;
            cond_r    <= cond;
            kind_r    <= kind;
        end
    end

    // operands and instruction word
    always_ff @(posedge clk) begin
        if (transfer) begin
            rs_r    <= rs_value;
            rt_r    <= rt_value;
            instr_r <= branch_instr;
        end
    end

endmodule

`default_nettype wire

//--- rtl/pc_select.sv
`default_nettype none

`include "fetch_cfg.svh"

module pc_select (
    input  wire logic [31:0] target,
    input  wire logic        rst_n,
    input  wire logic        taken,
    input  wire logic [31:0] seq_pc_r,
    input  wire logic [31:0] inst_sram_rdata,
    output logic [31:0]      fetch_pc,
    output logic [31:0]      fetch_pc_plus4,
    output logic [31:0]      fetch_pc_plus8,
    output logic [31:0]      fetch_instr,
    output logic [31:0]      inst_sram_addr,
    output logic             inst_sram_en,
    output logic             fetch_exc,
    output logic [7:0]       exc_code
);

    logic in_kseg;
    logic misaligned;

    // ----------------------------------------------------------------------
    // next pc
    // ----------------------------------------------------------------------
    assign fetch_pc       = taken ? target : seq_pc_r;
    assign fetch_pc_plus4 = fetch_pc + 32'd4;
    assign fetch_pc_plus8 = fetch_pc + 32'd8;

    // ----------------------------------------------------------------------
    // fixed mapping
    // ----------------------------------------------------------------------
    assign in_kseg = (fetch_pc >= `FETCH_KSEG_LO) && (fetch_pc <= `FETCH_KSEG_HI);

    always_comb begin
        if (in_kseg) begin
            // kseg0/kseg1 both fold onto the low 512 MB
            inst_sram_addr = {3'b000, fetch_pc[28:0]};
        end else begin
            inst_sram_addr = fetch_pc;
        end
    end

    // ----------------------------------------------------------------------
    // alignment check and sram enable
    // ----------------------------------------------------------------------
    assign misaligned = (fetch_pc[1:0] != 2'b00);

    always_comb begin
        if (misaligned) begin
            fetch_exc    = 1'b1;
            exc_code     = `FETCH_EXC_ADEL;
            inst_sram_en = 1'b0;
        end else begin
            fetch_exc    = 1'b0;
            exc_code     = 8'h00;
            inst_sram_en = rst_n;
        end
    end

    // read data goes straight to decode
    assign fetch_instr = inst_sram_rdata;

endmodule

`default_nettype wire

//--- rtl/fetch_unit.sv
`default_nettype none

module fetch_unit
    import fetch_pkg::*;
(
    input  wire logic         clk,
    input  wire logic         rst_n,
    input  wire logic         id_allowin,
    input  wire logic [31:0]  seq_pc,
    input  wire logic [31:0]  rs_value,
    input  wire logic [31:0]  rt_value,
    input  wire instr_word_u  branch_instr,
    input  wire branch_cond_e cond,
    input  wire target_kind_e kind,
    input  wire logic [31:0]  inst_sram_rdata,
    output logic              if_valid,
    output logic [31:0]       fetch_pc,
    output logic [31:0]       fetch_pc_plus4,
    output logic [31:0]       fetch_pc_plus8,
    output logic [31:0]       fetch_instr,
    output logic              fetch_exc,
    output logic [7:0]        exc_code,
    output logic [31:0]       inst_sram_addr,
    output logic              inst_sram_en
);

    logic [31:0]  seq_pc_r;
    logic [31:0]  base_pc_r;
    logic [31:0]  rs_r;
    logic [31:0]  rt_r;
    instr_word_u  instr_r;
    branch_cond_e cond_r;
    target_kind_e kind_r;
    logic         taken;
    logic [31:0]  target;

    // ----------------------------------------------------------------------
    // redirect registers
    // ----------------------------------------------------------------------
    redirect_latch u_redirect_latch (
        .clk          (clk),
        .rst_n        (rst_n),
        .id_allowin   (id_allowin),
        .seq_pc       (seq_pc),
        .rs_value     (rs_value),
        .rt_value     (rt_value),
        .branch_instr (branch_instr),
        .cond         (cond),
        .kind         (kind),
        .fetch_pc     (fetch_pc),
        .if_valid     (if_valid),
        .seq_pc_r     (seq_pc_r),
        .base_pc_r    (base_pc_r),
        .rs_r         (rs_r),
        .rt_r         (rt_r),
        .instr_r      (instr_r),
        .cond_r       (cond_r),
        .kind_r       (kind_r)
    );

    // ----------------------------------------------------------------------
    // taken decision and target, side by side
    // ----------------------------------------------------------------------
    branch_cond u_branch_cond (
        .rs_r   (rs_r),
        .cond_r (cond_r),
        .rt_r   (rt_r),
        .taken  (taken)
    );

    target_calc u_target_calc (
        .base_pc_r (base_pc_r),
        .rs_r      (rs_r),
        .instr_r   (instr_r),
        .kind_r    (kind_r),
        .target    (target)
    );

    // pc mux, mapping and sram side
    pc_select u_pc_select (
        .target          (target),
        .rst_n           (rst_n),
        .taken           (taken),
        .seq_pc_r        (seq_pc_r),
        .inst_sram_rdata (inst_sram_rdata),
        .fetch_pc        (fetch_pc),
        .fetch_pc_plus4  (fetch_pc_plus4),
        .fetch_pc_plus8  (fetch_pc_plus8),
        .fetch_instr     (fetch_instr),
        .inst_sram_addr  (inst_sram_addr),
        .inst_sram_en    (inst_sram_en),
        .fetch_exc       (fetch_exc),
        .exc_code        (exc_code)
    );

endmodule

`default_nettype wire

//--- test/clock_gen.sv
`default_nettype none

module clock_gen (
    output logic clk
);

    // period of 100, starts low
    initial begin
        clk = 1'b0;
    end

    always #50 clk = ~clk;

endmodule

`default_nettype wire

//--- test/fetch_tb.sv
`default_nettype none

`include "fetch_cfg.svh"

module fetch_tb
    import fetch_pkg::*;
();

    localparam int RESET_CYCLES = 3;

    // one line of the vector file as 32-bit hex fields
    typedef struct packed {
        logic [31:0] seq_pc;
        logic [31:0] rs_value;
        logic [31:0] rt_value;
        logic [31:0] instr;
        logic [31:0] cond;
        logic [31:0] kind;
        logic [31:0] allowin;
        logic [31:0] rdata;
        logic [31:0] exp_pc;
        logic [31:0] exp_addr;
        logic [31:0] exp_exc;
        logic [31:0] exp_valid;
        logic [31:0] exp_instr;
    } vector_t;

    logic         clk;
    logic         rst_n;
    logic         id_allowin;
    logic [31:0]  seq_pc;
    logic [31:0]  rs_value;
    logic [31:0]  rt_value;
    logic [31:0]  branch_instr;
    branch_cond_e cond;
    target_kind_e kind;
    logic [31:0]  inst_sram_rdata;
    logic         if_valid;
    logic [31:0]  fetch_pc;
    logic [31:0]  fetch_pc_plus4;
    logic [31:0]  fetch_pc_plus8;
    logic [31:0]  fetch_instr;
    logic         fetch_exc;
    logic [7:0]   exc_code;
    logic [31:0]  inst_sram_addr;
    logic         inst_sram_en;

    vector_t      vec_q[$];
    string        name_q[$];
    int           cycle_count = 0;
    int           cycle_limit;

    clock_gen clk_gen0 (
        .clk (clk)
    );

    fetch_unit dut0 (
        .clk             (clk),
        .rst_n           (rst_n),
        .id_allowin      (id_allowin),
        .seq_pc          (seq_pc),
        .rs_value        (rs_value),
        .rt_value        (rt_value),
        .branch_instr    (branch_instr),
        .cond            (cond),
        .kind            (kind),
        .inst_sram_rdata (inst_sram_rdata),
        .if_valid        (if_valid),
        .fetch_pc        (fetch_pc),
        .fetch_pc_plus4  (fetch_pc_plus4),
        .fetch_pc_plus8  (fetch_pc_plus8),
        .fetch_instr     (fetch_instr),
        .fetch_exc       (fetch_exc),
        .exc_code        (exc_code),
        .inst_sram_addr  (inst_sram_addr),
        .inst_sram_en    (inst_sram_en)
    );

    // ----------------------------------------------------------------------
    // error handling and checks
    // ----------------------------------------------------------------------
    task automatic fail_run(input string msg);
        $display("%0s", msg);
        $display("Some tests failed");
        $fatal(1, "simulation stopped on error");
    endtask

    task automatic check_value(input string test_name, input string signal_name,
                               input logic [31:0] expected, input logic [31:0] actual);
        if (actual !== expected) begin
            fail_run($sformatf("Fail %0s %0s: expected %h, actual %h",
                               test_name, signal_name, expected, actual));
        end
    endtask

    // watchdog on rising edges
    always @(posedge clk) begin
        cycle_count <= cycle_count + 1;
        if (cycle_count >= cycle_limit) begin
            fail_run($sformatf("timeout: run went past %0d clock cycles", cycle_limit));
        end
    end

    // ----------------------------------------------------------------------
    // vector file
    // ----------------------------------------------------------------------
    task automatic load_vectors();
        int               fd;
        int               n;
        logic [8*128-1:0] line_buf;
        logic [8*16-1:0]  name_buf;
        vector_t          v;
        fd = $fopen("test/fetch_vectors.txt", "r");
        if (fd == 0) begin
            fail_run("could not open test/fetch_vectors.txt");
        end
        while ($fgets(line_buf, fd) != 0) begin
            name_buf = '0;
            n = $sscanf(line_buf, "%s %h %h %h %h %h %h %h %h %h %h %h %h %h", name_buf,
                        v.seq_pc, v.rs_value, v.rt_value, v.instr, v.cond, v.kind,
                        v.allowin, v.rdata, v.exp_pc, v.exp_addr, v.exp_exc,
                        v.exp_valid, v.exp_instr);
            // lines whose first word is a lone # are comments
            if (n > 0 && name_buf != {120'd0, "#"}) begin
                if (n != 14) begin
                    fail_run($sformatf("malformed line in vector file: %0s", line_buf));
                end
                vec_q.push_back(v);
                name_q.push_back(string'(name_buf));
            end
        end
        $fclose(fd);
    endtask

    task automatic drive_vector(input int idx);
        vector_t v;
        v = vec_q[idx];
        id_allowin      = v.allowin[0];
        seq_pc          = v.seq_pc;
        rs_value        = v.rs_value;
        rt_value        = v.rt_value;
        branch_instr    = v.instr;
        cond            = branch_cond_e'(v.cond[2:0]);
        kind            = target_kind_e'(v.kind[1:0]);
        inst_sram_rdata = v.rdata;
        // fields the condition never reads get random values
        if (cond == cond_none) begin
            rs_value     = $urandom;
            rt_value     = $urandom;
            branch_instr = $urandom;
        end else if (cond != cond_eq && cond != cond_ne) begin
            rt_value = $urandom;
        end
    endtask

    task automatic check_vector(input int idx);
        vector_t v;
        string   test_name;
        v = vec_q[idx];
        test_name = name_q[idx];
        check_value(test_name, "fetch_pc", v.exp_pc, fetch_pc);
        check_value(test_name, "fetch_pc_plus4", v.exp_pc + 32'd4, fetch_pc_plus4);
        check_value(test_name, "fetch_pc_plus8", v.exp_pc + 32'd8, fetch_pc_plus8);
        check_value(test_name, "inst_sram_addr", v.exp_addr, inst_sram_addr);
        check_value(test_name, "fetch_exc", v.exp_exc, 32'(fetch_exc));
        // address error code only with the exception
        check_value(test_name, "exc_code", v.exp_exc[0] ? 32'(`FETCH_EXC_ADEL) : 32'd0,
                    32'(exc_code));
        // sram off while the exception is up
        check_value(test_name, "inst_sram_en", 32'(!v.exp_exc[0]), 32'(inst_sram_en));
        check_value(test_name, "if_valid", v.exp_valid, 32'(if_valid));
        check_value(test_name, "fetch_instr", v.exp_instr, fetch_instr);
    endtask

    // ----------------------------------------------------------------------
    // main sequence
    // ----------------------------------------------------------------------
    initial begin
        rst_n           = 1'b0;
        id_allowin      = 1'b0;
        seq_pc          = 32'd0;
        rs_value        = 32'd0;
        rt_value        = 32'd0;
        branch_instr    = 32'd0;
        cond            = cond_none;
        kind            = tk_rel;
        inst_sram_rdata = 32'd0;
        cycle_limit     = RESET_CYCLES + 20;
        void'($urandom(65025));

        repeat (RESET_CYCLES) @(posedge clk);
        @(negedge clk);
        // boot pc and an idle stage while still in reset
        check_value("reset", "if_valid", 32'd0, 32'(if_valid));
        check_value("reset", "fetch_pc", `FETCH_RESET_PC, fetch_pc);
        check_value("reset", "inst_sram_addr", 32'h1FC0_0000, inst_sram_addr);
        check_value("reset", "inst_sram_en", 32'd0, 32'(inst_sram_en));

        load_vectors();
        if (vec_q.size() == 0) begin
            fail_run("vector file holds no vectors");
        end
        cycle_limit = RESET_CYCLES + vec_q.size() + 20;

        rst_n = 1'b1;
        // each vector is checked one cycle after it is driven
        for (int i = 0; i < vec_q.size(); i++) begin
            drive_vector(i);
            @(negedge clk);
            check_vector(i);
        end

        $display("All tests passed");
        $finish;
    end

endmodule

`default_nettype wire

//--- test/fetch_vectors.txt
# name seq_pc rs_value rt_value branch_instr cond kind id_allowin inst_sram_rdata, then expected
# fetch_pc inst_sram_addr fetch_exc if_valid fetch_instr one cycle later, all hex
# cond 0 none 1 eq 2 ne 3 gez 4 gtz 5 lez 6 ltz 7 always, kind 0 rel 1 abs 2 reg
boot      BFC00004 00000000 00000000 00000000 0 0 0 3C1D0000 BFC00000 1FC00000 0 1 3C1D0000
seq_1     BFC00004 00000000 00000000 00000000 0 0 1 27BDFFF0 BFC00004 1FC00004 0 1 27BDFFF0
seq_2     BFC00008 00000000 00000000 00000000 0 0 1 AFBF000C BFC00008 1FC00008 0 1 AFBF000C
seq_3     BFC0000C 00000000 00000000 00000000 0 0 1 00000000 BFC0000C 1FC0000C 0 1 00000000
beq_t     BFC00010 00001234 00001234 10000010 1 0 1 8FA40000 BFC0004C 1FC0004C 0 1 8FA40000
beq_nt    BFC00050 00001234 00001235 10000010 1 0 1 24020001 BFC00050 1FC00050 0 1 24020001
bne_t     BFC00054 00000005 00000006 1400FFF0 2 0 1 00851021 BFC00010 1FC00010 0 1 00851021
bne_nt    BFC00014 00000007 00000007 1400FFF0 2 0 1 03E00008 BFC00014 1FC00014 0 1 03E00008
bgez_t    BFC00018 00000000 00000000 04010008 3 0 1 8C820004 BFC00034 1FC00034 0 1 8C820004
bgez_nt   BFC00038 80000000 00000000 04010008 3 0 1 AC430008 BFC00038 1FC00038 0 1 AC430008
bgtz_t    BFC0003C 00000001 00000000 1C000004 4 0 1 00432021 BFC00048 1FC00048 0 1 00432021
bgtz_nt   BFC0004C 00000000 00000000 1C000004 4 0 1 3484FFFF BFC0004C 1FC0004C 0 1 3484FFFF
blez_t    BFC00050 00000000 00000000 18000002 5 0 1 00042080 BFC00054 1FC00054 0 1 00042080
blez_nt   BFC00058 00000005 00000000 18000002 5 0 1 2484FFFC BFC00058 1FC00058 0 1 2484FFFC
bltz_t    BFC0005C FFFFFFFF 00000000 0400FFFE 6 0 1 0C0F0010 BFC00050 1FC00050 0 1 0C0F0010
bltz_nt   BFC00054 00000000 00000000 0400FFFE 6 0 1 00000000 BFC00054 1FC00054 0 1 00000000
j_abs     BFC00058 00000000 00000000 08000100 7 1 1 8E080000 B0000400 10000400 0 1 8E080000
jr_reg    B0000404 9FC00100 00000000 03E00008 7 2 1 3C08A000 9FC00100 1FC00100 0 1 3C08A000
stall_1   12345678 FFFFFFFF 00000000 00000000 7 2 0 11110000 9FC00100 1FC00100 0 1 11110000
stall_2   00000000 00000001 00000001 FFFFFFFF 1 0 0 22220000 9FC00100 1FC00100 0 1 22220000
user_seg  00400000 00000000 00000000 00000000 0 0 1 35080001 00400000 00400000 0 1 35080001
kseg2_jr  00400004 C0001000 00000000 03E00008 7 2 1 AD090000 C0001000 C0001000 0 1 AD090000
kseg_lo   80000000 00000000 00000000 00000000 0 0 1 01095021 80000000 00000000 0 1 01095021
misalign  80000004 80000102 00000000 00000000 7 2 1 DEADBEEF 80000102 00000102 1 1 DEADBEEF
recover   00400008 00000000 00000000 00000000 0 0 1 254A0001 00400008 00400008 0 1 254A0001
kseg1_end BFFFFFFC 00000000 00000000 00000000 0 0 1 1540FFFE BFFFFFFC 1FFFFFFC 0 1 1540FFFE
j_region  00000000 00000000 00000000 0C100010 7 1 1 0000000C B0400040 10400040 0 1 0000000C
final_seq 00400010 00000000 00000000 00000000 0 0 1 42000018 00400010 00400010 0 1 42000018

//--- files.f
+incdir+common
common/fetch_pkg.sv
rtl/branch/branch_cond.sv
rtl/branch/target_calc.sv
rtl/redirect_latch.sv
rtl/pc_select.sv
rtl/fetch_unit.sv
test/clock_gen.sv
test/fetch_tb.sv

//--- Makefile
SRCS := $(filter-out +%,$(shell cat files.f)) common/fetch_cfg.svh

.PHONY: run clean

run: obj_dir/Vfetch_tb test/fetch_vectors.txt
	./obj_dir/Vfetch_tb > sim.log 2>&1; cat sim.log
	grep -q "All tests passed" sim.log

obj_dir/Vfetch_tb: files.f $(SRCS)
	verilator --binary --top-module fetch_tb -f files.f

clean:
	rm -rf obj_dir sim.log
